/* Makefile */
TOP := cache_top_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f cache_sub.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* cache_sub.f */
hw/cache_pkg.sv
hw/cache_ctrl.sv
hw/cache_tags.sv
hw/cache_data.sv
hw/line_buffer.sv
hw/main_mem.sv
hw/cache_top.sv
dv/cache_top_chk.sv
dv/cache_top_tb.sv

/* dv/cache_top_chk.sv */
`timescale 1ns/1ps

module cache_top_chk
    import cache_pkg::*;
(
    input logic        CLK,
    input logic        RST,
    input logic        cpu_ready,
    input logic        fill_we,
    input logic        mem_we,
    input logic        mem_tick,
    input logic        buf_load,
    input ctrl_state_t state
);

    a_ready_vs_fill: assert property (@(posedge CLK) disable iff (RST) !(cpu_ready && fill_we))
        else $error("cpu_ready and fill_we high in the same cycle");

    a_write_on_tick: assert property (@(posedge CLK) disable iff (RST) mem_we |-> mem_tick)
        else $error("memory write outside a memory tick");

    a_fill_state: assert property (@(posedge CLK) disable iff (RST)
                                   fill_we |-> state == st_write_cache)
        else $error("fill_we outside st_write_cache");

    a_load_after_reset: assert property (@(posedge CLK) RST |=> !buf_load)
        else $error("buffer load right after reset");

endmodule

bind cache_ctrl cache_top_chk i_chk (
    .CLK(CLK), .RST(RST), .cpu_ready(cpu_ready), .fill_we(fill_we),
    .mem_we(mem_we), .mem_tick(mem_tick), .buf_load(buf_load), .state(state_q)
);

/* dv/cache_top_tb.sv */
`timescale 1ns/1ps

module cache_top_tb;
    import cache_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int N_DIRECTED   = 16;                   // upper bound on directed requests
    localparam int N_RANDOM     = 300;
    localparam int NUM_REQ      = N_DIRECTED + N_RANDOM;
    localparam int MISS_BOUND   = 40;                   // worst dirty miss, in cycles
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_REQ * MISS_BOUND;

    logic  CLK;
    logic  RST;
    logic  cpu_req;
    logic  cpu_we;
    addr_t cpu_addr;
    data_t cpu_wdata;
    logic  cpu_ready;
    data_t cpu_rdata;

    data_t shadow [2**ADDR_W];
    int    seed = 32'hbc79_1d58;
    int    checks = 0;
    int    errors = 0;

    cache_top #(.MEM_DIV(4)) i_dut (
        .CLK(CLK), .RST(RST), .cpu_req(cpu_req), .cpu_we(cpu_we),
        .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_ready(cpu_ready),
        .cpu_rdata(cpu_rdata)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // expected read data, taken from the shadow copy of memory
    function automatic data_t expected_word(input addr_t a);
        return shadow[a];
    endfunction

    // issue one request and hold it until cpu_ready
    task automatic do_request(input logic we, input addr_t addr, input data_t wdata,
                              output int wait_cycles);
        @(posedge CLK);
        #1;
        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        wait_cycles = 0;
        @(negedge CLK);
        while (!cpu_ready) begin
            wait_cycles++;
            @(negedge CLK);
        end
        @(posedge CLK);                                 // write lands on this edge
        #1;
        cpu_req = 1'b0;
        cpu_we  = 1'b0;
        if (we) begin
            shadow[addr] = wdata;
        end
    endtask

    task automatic read_word(input addr_t addr, output int wait_cycles);
        do_request(1'b0, addr, '0, wait_cycles);
    endtask

    task automatic write_word(input addr_t addr, input data_t wdata);
        int lat;
        do_request(1'b1, addr, wdata, lat);
    endtask

    task automatic expect_latency(input addr_t addr, input int got, input bit is_hit);
        checks++;
        if (is_hit && got != 0) begin
            errors++;
            $display("Error at %0t: hit on %h took %0d cycles, expected 0", $time, addr, got);
        end
        if (!is_hit && got == 0) begin
            errors++;
            $display("Error at %0t: miss on %h answered at once", $time, addr);
        end
    endtask

    // read data checked against the reference on every served read
    always @(negedge CLK) begin
        if (!RST && cpu_ready && !cpu_we) begin
            checks++;
            if (cpu_rdata !== expected_word(cpu_addr)) begin
                errors++;
                $display("Error at %0t: read %h returned %h, expected %h", $time,
                         cpu_addr, cpu_rdata, expected_word(cpu_addr));
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the cache stopped answering requests");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int    lat;
        int    r;
        logic  we;
        addr_t a;
        data_t wd;

        CLK       = 1'b0;
        RST       = 1'b1;
        cpu_req   = 1'b0;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        for (int i = 0; i < 2**ADDR_W; i++) begin
            shadow[i] = DATA_W'(i) ^ 32'ha5a5_0000;     // same start as main memory
        end
        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RST = 1'b0;

        // clean misses after reset
        read_word(12'h000, lat);
        expect_latency(12'h000, lat, 1'b0);
        read_word(12'h013, lat);
        expect_latency(12'h013, lat, 1'b0);
        read_word(12'h2a7, lat);
        expect_latency(12'h2a7, lat, 1'b0);
        read_word(12'hfff, lat);
        expect_latency(12'hfff, lat, 1'b0);

        // same line again, served in the request cycle
        read_word(12'h2a5, lat);
        expect_latency(12'h2a5, lat, 1'b1);
        read_word(12'h2a7, lat);
        expect_latency(12'h2a7, lat, 1'b1);

        // write hit then read back
        write_word(12'h013, 32'hdead_beef);
        read_word(12'h013, lat);
        expect_latency(12'h013, lat, 1'b1);

        // dirty line pushed out by a conflicting tag, then refilled
        write_word(12'h0c8, 32'h1234_5678);
        write_word(12'h0c9, 32'hcafe_f00d);
        read_word(12'h0c8 ^ 12'h040, lat);              // same index, other tag
        expect_latency(12'h088, lat, 1'b0);
        read_word(12'h0c8, lat);
        expect_latency(12'h0c8, lat, 1'b0);
        read_word(12'h0c9, lat);

        // random mix over 4 tags and 2 lines
        for (int n = 0; n < N_RANDOM; n++) begin
            r  = $random(seed);
            we = r[5];
            a  = '0;
            a[7:6] = r[1:0];
            a[2]   = r[2];
            a[1:0] = r[4:3];
            wd = $random(seed);
            if (we) begin
                write_word(a, wd);
            end else begin
                read_word(a, lat);
            end
        end

        repeat (2) @(posedge CLK);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* hw/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic CLK,
    input  logic RST,
    input  logic cpu_req,
    input  logic hit,
    input  logic victim_dirty,
    input  logic buf_full,
    input  logic buf_dirty,
    input  logic mem_tick,
    output logic cpu_ready,
    output logic buf_clr,
    output logic buf_next,
    output logic buf_from_mem,
    output logic buf_load,
    output logic mem_we,
    output logic fill_we
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    always_ff @(posedge CLK) begin
        if (RST) begin
            state_q <= st_check;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        cpu_ready    = 1'b0;
        buf_clr      = 1'b0;
        buf_next     = 1'b0;
        buf_from_mem = 1'b0;
        buf_load     = 1'b0;
        mem_we       = 1'b0;
        fill_we      = 1'b0;

        case (state_q)
            st_check: begin
                if (cpu_req && hit) begin
                    cpu_ready = 1'b1;                 // served this cycle
                end else if (cpu_req) begin
                    buf_clr = 1'b1;
                    if (victim_dirty) begin
                        state_d = st_fill_dirty;      // victim must go back first
                    end else begin
                        state_d = st_load_write_mem;
                    end
                end
            end

            st_fill_dirty: begin
                // copy victim line out of the data array
                buf_load = mem_tick;
                buf_next = mem_tick;
                if (buf_full) begin
                    state_d = st_load_write_mem;
                end
            end

            st_load_write_mem: begin
                buf_from_mem = 1'b1;
                buf_load     = mem_tick;
                buf_next     = mem_tick;
                mem_we       = buf_dirty & mem_tick;  // old word out, new word in
                if (buf_full) begin
                    state_d = st_write_cache;
                end
            end

            st_write_cache: begin
                fill_we  = 1'b1;
                buf_next = 1'b1;
                if (buf_full) begin
                    state_d = st_check;               // request retried as a hit
                end
            end

            default: begin
                state_d = st_check;
            end
        endcase
    end

endmodule

/* hw/cache_data.sv */
`timescale 1ns/1ps

module cache_data
    import cache_pkg::*;
(
    input  logic    CLK,
    input  logic    cpu_we,
    input  logic    cpu_ready,
    input  logic    fill_we,
    input  addr_t   cpu_addr,
    input  offset_t word_sel,
    input  data_t   cpu_wdata,
    input  data_t   fill_wdata,
    output data_t   cpu_rdata,
    output data_t   line_rdata
);

    localparam int WORDS = NUM_LINES * LINE_WORDS;
    localparam int WA_W  = INDEX_W + OFFSET_W;

    data_t data_q [WORDS];

    logic [WA_W-1:0] cpu_wa;
    logic [WA_W-1:0] line_wa;

    assign cpu_wa  = cpu_addr[WA_W-1:0];                            // {index, offset}
    assign line_wa = {cpu_addr[OFFSET_W +: INDEX_W], word_sel};     // same line, buffer word

    assign cpu_rdata  = data_q[cpu_wa];
    assign line_rdata = data_q[line_wa];

    // both ports never write in the same cycle
    always_ff @(posedge CLK) begin
        if (fill_we) begin
            data_q[line_wa] <= fill_wdata;
        end else if (cpu_ready && cpu_we) begin
            data_q[cpu_wa] <= cpu_wdata;
        end
    end

endmodule

/* hw/cache_pkg.sv */
package cache_pkg;

    // word address split as {tag, index, offset}
    parameter int ADDR_W   = 12;
    parameter int DATA_W   = 32;
    parameter int OFFSET_W = 2;
    parameter int INDEX_W  = 4;
    parameter int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    parameter int LINE_WORDS = 2 ** OFFSET_W;       // words per line
    parameter int NUM_LINES  = 2 ** INDEX_W;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // controller phases
    typedef enum logic [1:0] {
        st_check,
        st_fill_dirty,
        st_load_write_mem,
        st_write_cache
    } ctrl_state_t;

endpackage

/* hw/cache_tags.sv */
`timescale 1ns/1ps

module cache_tags
    import cache_pkg::*;
(
    input  logic  CLK,
    input  logic  RST,
    input  logic  cpu_req,
    input  logic  cpu_we,
    input  logic  cpu_ready,
    input  logic  fill_we,
    input  logic  buf_full,
    input  addr_t cpu_addr,
    output logic  hit,
    output logic  victim_dirty,
    output tag_t  victim_tag
);

    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;
    tag_t                 tag_q [NUM_LINES];

    tag_t   req_tag;
    index_t req_index;
    logic   fill_done;

    assign req_tag   = cpu_addr[ADDR_W-1 -: TAG_W];
    assign req_index = cpu_addr[OFFSET_W +: INDEX_W];
    assign fill_done = fill_we & buf_full;          // last word of refill

    assign hit          = cpu_req & valid_q[req_index] & (tag_q[req_index] == req_tag);
    assign victim_dirty = valid_q[req_index] & dirty_q[req_index];
    assign victim_tag   = tag_q[req_index];

    always_ff @(posedge CLK) begin
        if (RST) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (fill_done) begin
                valid_q[req_index] <= 1'b1;
                dirty_q[req_index] <= 1'b0;           // fresh copy of memory
            end else if (cpu_ready && cpu_we) begin
                dirty_q[req_index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fill_done) begin
            tag_q[req_index] <= req_tag;
        end
    end

endmodule

/* hw/cache_top.sv */
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
#(
    parameter int MEM_DIV = 4
) (
    input  logic  CLK,
    input  logic  RST,
    input  logic  cpu_req,
    input  logic  cpu_we,
    input  addr_t cpu_addr,
    input  data_t cpu_wdata,
    output logic  cpu_ready,
    output data_t cpu_rdata
);

    logic    hit, victim_dirty, buf_full, buf_dirty, mem_tick;
    logic    buf_clr, buf_next, buf_from_mem, buf_load, mem_we, fill_we;
    tag_t    victim_tag;
    offset_t word_sel;
    data_t   line_rdata, buf_word, mem_rdata;
    addr_t   mem_rd_addr, mem_wr_addr;

    // victim goes back to its old home, new line comes from the request
    assign mem_wr_addr = {victim_tag, cpu_addr[OFFSET_W +: INDEX_W], word_sel};
    assign mem_rd_addr = {cpu_addr[ADDR_W-1 -: TAG_W], cpu_addr[OFFSET_W +: INDEX_W], word_sel};

    cache_ctrl i_ctrl (
        .CLK(CLK), .RST(RST), .cpu_req(cpu_req), .hit(hit),
        .victim_dirty(victim_dirty), .buf_full(buf_full), .buf_dirty(buf_dirty),
        .mem_tick(mem_tick), .cpu_ready(cpu_ready), .buf_clr(buf_clr),
        .buf_next(buf_next), .buf_from_mem(buf_from_mem), .buf_load(buf_load),
        .mem_we(mem_we), .fill_we(fill_we)
    );

    cache_tags i_tags (
        .CLK(CLK), .RST(RST), .cpu_req(cpu_req), .cpu_we(cpu_we),
        .cpu_ready(cpu_ready), .fill_we(fill_we), .buf_full(buf_full),
        .cpu_addr(cpu_addr), .hit(hit), .victim_dirty(victim_dirty),
        .victim_tag(victim_tag)
    );

    cache_data i_data (
        .CLK(CLK), .cpu_we(cpu_we), .cpu_ready(cpu_ready), .fill_we(fill_we),
        .cpu_addr(cpu_addr), .word_sel(word_sel), .cpu_wdata(cpu_wdata),
        .fill_wdata(buf_word), .cpu_rdata(cpu_rdata), .line_rdata(line_rdata)
    );

    line_buffer i_buf (
        .CLK(CLK), .RST(RST), .buf_clr(buf_clr), .buf_next(buf_next),
        .buf_load(buf_load), .buf_from_mem(buf_from_mem), .cache_word(line_rdata),
        .mem_word(mem_rdata), .word_sel(word_sel), .buf_word(buf_word),
        .buf_full(buf_full), .buf_dirty(buf_dirty)
    );

    main_mem #(.MEM_DIV(MEM_DIV)) i_mem (
        .CLK(CLK), .RST(RST), .mem_we(mem_we), .rd_addr(mem_rd_addr),
        .wr_addr(mem_wr_addr), .wr_data(buf_word), .rd_data(mem_rdata),
        .mem_tick(mem_tick)
    );

endmodule

/* hw/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer
    import cache_pkg::*;
(
    input  logic    CLK,
    input  logic    RST,
    input  logic    buf_clr,
    input  logic    buf_next,
    input  logic    buf_load,
    input  logic    buf_from_mem,
    input  data_t   cache_word,
    input  data_t   mem_word,
    output offset_t word_sel,
    output data_t   buf_word,
    output logic    buf_full,
    output logic    buf_dirty
);

    data_t   buf_q [LINE_WORDS];
    offset_t cnt_q;
    logic    dirty_q;
    data_t   load_word;

    assign word_sel  = cnt_q;
    assign buf_word  = buf_q[cnt_q];
    assign buf_dirty = dirty_q;
    assign load_word = buf_from_mem ? mem_word : cache_word;

    // high while the last word moves
    assign buf_full = buf_next & (cnt_q == offset_t'(LINE_WORDS - 1));

    always_ff @(posedge CLK) begin
        if (RST) begin
            cnt_q   <= '0;
            dirty_q <= 1'b0;
        end else if (buf_clr) begin
            cnt_q   <= '0;
            dirty_q <= 1'b0;
        end else begin
            if (buf_next) begin
                cnt_q <= cnt_q + 1'b1;                // wraps to word 0
            end
            if (buf_load && !buf_from_mem) begin
                dirty_q <= 1'b1;                      // holds a victim line
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (buf_load) begin
            buf_q[cnt_q] <= load_word;
        end
    end

endmodule

/* hw/main_mem.sv */
`timescale 1ns/1ps

module main_mem
    import cache_pkg::*;
#(
    parameter int MEM_DIV = 4
) (
    input  logic  CLK,
    input  logic  RST,
    input  logic  mem_we,
    input  addr_t rd_addr,
    input  addr_t wr_addr,
    input  data_t wr_data,
    output data_t rd_data,
    output logic  mem_tick
);

    localparam int DEPTH = 2 ** ADDR_W;
    localparam int CNT_W = $clog2(MEM_DIV);

    data_t            mem_q [DEPTH];
    logic [CNT_W-1:0] div_q;

    // each word starts as its own address with a fixed pattern
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem_q[i] = DATA_W'(i) ^ 32'ha5a5_0000;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            div_q <= '0;
        end else if (mem_tick) begin
            div_q <= '0;
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

    assign mem_tick = (div_q == CNT_W'(MEM_DIV - 1));   // one cycle in MEM_DIV

    assign rd_data = mem_q[rd_addr];

    always @(posedge CLK) begin
        if (mem_tick && mem_we) begin
            mem_q[wr_addr] <= wr_data;
        end
    end

endmodule
